// ==== project.f ====
src/hdmi_pkg.sv
src/video_timing.sv
src/period_scheduler.sv
src/tmds_channel.sv
src/hdmi_tx.sv
bench/hdmi_tx_assertions.sv
bench/hdmi_tx_tb.sv

// ==== bench/hdmi_tx_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HDMI transmitter testbench
// Random streams checked against a frame and TMDS model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module hdmi_tx_tb;

    localparam int h_active      = 16;
    localparam int h_front       = 4;
    localparam int h_sync        = 8;
    localparam int h_blank       = 64;
    localparam int v_active      = 4;
    localparam int v_blank       = 2;
    localparam int island_offset = 2;
    localparam int h_total       = h_active + h_blank;
    localparam int v_total       = v_active + v_blank;
    localparam int frame_cycles  = h_total * v_total;
    localparam int slot_col      = h_active + island_offset;
    localparam int clk_period    = 20;
    // Lead-in cycle, two frames, pipeline drain
    localparam int run_cycles    = 2 * frame_cycles + 3;
    localparam int timeout_ns    = (3 * frame_cycles + 50) * clk_period;

    localparam logic [9:0]  guard_a      = 10'b1011001100;
    localparam logic [9:0]  guard_b      = 10'b0100110011;
    localparam logic [29:0] reset_triple = {3{10'b1101010100}};

    typedef enum {
        p_control, p_video_pre, p_video_guard, p_video,
        p_island_pre, p_island_guard, p_island_data
    } period_t;

    logic        clk_pixel = 1'b0;
    logic        rst;
    logic [23:0] pixel_data;
    logic        pixel_valid;
    logic        pixel_ready;
    logic [8:0]  aux_data;
    logic        aux_valid;
    logic        aux_ready;
    logic [9:0]  tmds_ch0;
    logic [9:0]  tmds_ch1;
    logic [9:0]  tmds_ch2;
    logic [29:0] exp_now = reset_triple;
    logic [29:0] exp_d1 = reset_triple;
    logic [29:0] exp_d2 = reset_triple;
    logic        compare_on = 1'b0;
    integer      seed = 32'h8fda68d5;

    hdmi_tx #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync),
        .h_blank(h_blank), .v_active(v_active), .v_blank(v_blank),
        .island_offset(island_offset)
    ) uut (
        .clk_pixel(clk_pixel), .rst(rst),
        .pixel_data(pixel_data), .pixel_valid(pixel_valid), .pixel_ready(pixel_ready),
        .aux_data(aux_data), .aux_valid(aux_valid), .aux_ready(aux_ready),
        .tmds_ch0(tmds_ch0), .tmds_ch1(tmds_ch1), .tmds_ch2(tmds_ch2)
    );

    always #(clk_period / 2) clk_pixel = ~clk_pixel;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
        begin
            $display("ERR time=%0t %s got=%h expected=%h", $time, name, got, want);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    function automatic logic [9:0] control_char(input logic [1:0] c);
        case (c)
            2'b00:   return 10'b1101010100;
            2'b01:   return 10'b0010101011;
            2'b10:   return 10'b0101010100;
            default: return 10'b1010101011;
        endcase
    endfunction

    function automatic logic [9:0] terc4_char(input logic [3:0] d);
        case (d)
            4'h0:    return 10'b1010011100;
            4'h1:    return 10'b1001100011;
            4'h2:    return 10'b1011100100;
            4'h3:    return 10'b1011100010;
            4'h4:    return 10'b0101110001;
            4'h5:    return 10'b0100011110;
            4'h6:    return 10'b0110001110;
            4'h7:    return 10'b0100111100;
            4'h8:    return 10'b1011001100;
            4'h9:    return 10'b0100111001;
            4'ha:    return 10'b0110011100;
            4'hb:    return 10'b1011000110;
            4'hc:    return 10'b1010001110;
            4'hd:    return 10'b1001110001;
            4'he:    return 10'b0101100011;
            default: return 10'b1011000011;
        endcase
    endfunction

    // One video character; returns {new disparity, character}
    function automatic logic [17:0] encode_video(input logic [7:0] d, input int disp);
        logic [8:0] qm;
        logic [9:0] code;
        int         ones_d;
        int         bal;
        bit         xnor_mode;
        ones_d = 0;
        for (int i = 0; i < 8; i++)
            ones_d += d[i];
        xnor_mode = (ones_d > 4) || (ones_d == 4 && d[0] == 1'b0);
        qm[0] = d[0];
        for (int i = 1; i < 8; i++)
            qm[i] = xnor_mode ? (qm[i-1] ~^ d[i]) : (qm[i-1] ^ d[i]);
        qm[8] = !xnor_mode;
        // Ones minus zeros over the coded byte
        bal = -8;
        for (int i = 0; i < 8; i++)
            bal += 2 * qm[i];
        if (disp == 0 || bal == 0)
        begin
            code = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            disp = qm[8] ? disp + bal : disp - bal;
        end
        else if ((disp > 0 && bal > 0) || (disp < 0 && bal < 0))
        begin
            code = {1'b1, qm[8], ~qm[7:0]};
            disp = disp - bal + (qm[8] ? 2 : 0);
        end
        else
        begin
            code = {1'b0, qm[8], qm[7:0]};
            disp = disp + bal - (qm[8] ? 0 : 2);
        end
        return {8'(disp), code};
    endfunction

    // Link period of one frame position
    function automatic period_t period_at(input int col, input int row, input bit island_line);
        int step;
        bit next_active;
        step        = col - slot_col;
        next_active = (row == v_total - 1) || (row + 1 < v_active);
        if (col < h_active && row < v_active)
            return p_video;
        if (island_line && step >= 0 && step < 44)
        begin
            if (step < 8)
                return p_island_pre;
            else if (step < 10 || step >= 42)
                return p_island_guard;
            else
                return p_island_data;
        end
        if (next_active && col >= h_total - 2)
            return p_video_guard;
        if (next_active && col >= h_total - 10)
            return p_video_pre;
        return p_control;
    endfunction

    // Expected characters trail the position by two clocks
    always @(posedge clk_pixel)
    begin
        exp_d1 <= exp_now;
        exp_d2 <= exp_d1;
    end

    always @(negedge clk_pixel)
    begin
        if (compare_on)
        begin
            check_value("tmds_ch0", tmds_ch0, exp_d2[9:0]);
            check_value("tmds_ch1", tmds_ch1, exp_d2[19:10]);
            check_value("tmds_ch2", tmds_ch2, exp_d2[29:20]);
        end
    end

    initial
    begin
        #(timeout_ns);
        $display("Watchdog expired after %0d ns before the run finished", timeout_ns);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial
    begin
        int          col;
        int          row;
        int          disp [3];
        int          islands;
        int          skipped;
        bit          island_line;
        bit          hs;
        bit          vs;
        bit          first;
        period_t     per;
        logic [9:0]  ch [3];
        logic [17:0] enc;
        logic [3:0]  ctl;
        logic [8:0]  word;
        logic [23:0] pix;
        logic        got_pix_rdy;
        logic        got_aux_rdy;

        rst         = 1'b1;
        pixel_data  = '0;
        pixel_valid = 1'b0;
        aux_data    = '0;
        aux_valid   = 1'b0;
        col         = h_total - 1;
        row         = v_total - 1;
        islands     = 0;
        skipped     = 0;
        island_line = 1'b0;
        for (int n = 0; n < 3; n++)
            disp[n] = 0;

        @(posedge clk_pixel);
        compare_on = 1'b1;
        @(posedge clk_pixel);
        @(negedge clk_pixel);
        rst = 1'b0;

        // First model cycle is the parked position before 0,0
        for (int k = 0; k < run_cycles; k++)
        begin
            got_pix_rdy = pixel_ready;
            got_aux_rdy = aux_ready;
            pixel_data  = 24'($random(seed));
            pixel_valid = ($random(seed) & 7) != 0;
            aux_data    = 9'($random(seed));
            if (col == slot_col)
                aux_valid = ($random(seed) & 1) != 0;
            else
                aux_valid = ($random(seed) & 15) != 0;

            hs = (col >= h_active + h_front) && (col < h_active + h_front + h_sync);
            vs = (row == v_active);
            if (col == slot_col)
            begin
                island_line = aux_valid;
                if (aux_valid)
                    islands++;
                else
                    skipped++;
            end
            per = period_at(col, row, island_line);
            check_value("pixel_ready", got_pix_rdy, per == p_video);
            check_value("aux_ready", got_aux_rdy, per == p_island_data);

            ctl  = 4'b0000;
            pix  = pixel_valid ? pixel_data : 24'h0;
            word = aux_valid ? aux_data : 9'h0;
            if (per != p_video)
            begin
                for (int n = 0; n < 3; n++)
                    disp[n] = 0;
            end
            case (per)
                p_video:
                begin
                    for (int n = 0; n < 3; n++)
                    begin
                        enc     = encode_video(pix[8*n +: 8], disp[n]);
                        ch[n]   = enc[9:0];
                        disp[n] = $signed(enc[17:10]);
                    end
                end
                p_video_guard:
                begin
                    ch[0] = guard_a;
                    ch[1] = guard_b;
                    ch[2] = guard_a;
                end
                p_island_guard:
                begin
                    ch[0] = terc4_char({2'b11, vs, hs});
                    ch[1] = guard_b;
                    ch[2] = guard_b;
                end
                p_island_data:
                begin
                    first = (col == slot_col + 10);
                    ch[0] = terc4_char({!first, word[0], vs, hs});
                    ch[1] = terc4_char(word[4:1]);
                    ch[2] = terc4_char(word[8:5]);
                end
                default:
                begin
                    // CTL0 marks both preambles, CTL2 only the island one
                    if (per == p_video_pre)
                        ctl = 4'b0001;
                    if (per == p_island_pre)
                        ctl = 4'b0101;
                    ch[0] = control_char({vs, hs});
                    ch[1] = control_char(ctl[1:0]);
                    ch[2] = control_char(ctl[3:2]);
                end
            endcase
            exp_now = {ch[2], ch[1], ch[0]};

            if (col == h_total - 1)
            begin
                col = 0;
                row = (row == v_total - 1) ? 0 : row + 1;
            end
            else
                col++;
            @(negedge clk_pixel);
        end

        @(posedge clk_pixel);
        compare_on = 1'b0;
        if (islands == 0 || skipped == 0)
        begin
            $display("Island slots not seen both ways: %0d taken, %0d skipped",
                     islands, skipped);
            $display("TEST RESULT: FAIL");
            $fatal(1, "island coverage");
        end
        else
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== bench/hdmi_tx_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HDMI transmitter assertions
// Ready windows and reset state of both streams
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module hdmi_tx_assertions
#(
    parameter int h_active      = 1280,
    parameter int h_blank       = 370,
    parameter int v_active      = 720,
    parameter int v_blank       = 30,
    parameter int island_offset = 4
)
(
    input logic                                     clk_pixel,
    input logic                                     rst,
    input logic [$clog2(h_active + h_blank) - 1:0] column,
    input logic [$clog2(v_active + v_blank) - 1:0] row,
    input logic                                     pixel_ready,
    input logic                                     aux_ready
);

    // Island data window relative to the slot column
    localparam int data_first = h_active + island_offset + hdmi_pkg::preamble_len
                              + hdmi_pkg::guard_len;
    localparam int data_last  = data_first + hdmi_pkg::island_len - 1;

    // Pixels are taken only inside active video
    assert property (@(posedge clk_pixel) disable iff (rst)
        pixel_ready |-> (column < h_active) && (row < v_active))
        else $error("pixel_ready high outside active video");

    // Aux words are taken only on island data clocks
    assert property (@(posedge clk_pixel) disable iff (rst)
        aux_ready |-> (column >= data_first) && (column <= data_last))
        else $error("aux_ready high outside island data");

    assert property (@(posedge clk_pixel) rst |=> !pixel_ready && !aux_ready)
        else $error("ready signal high in the cycle after reset");

endmodule

bind hdmi_tx hdmi_tx_assertions #(
    .h_active(h_active), .h_blank(h_blank), .v_active(v_active),
    .v_blank(v_blank), .island_offset(island_offset)
) handshake_checks (
    .clk_pixel(clk_pixel), .rst(rst), .column(column), .row(row),
    .pixel_ready(pixel_ready), .aux_ready(aux_ready)
);

// ==== src/hdmi_tx.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HDMI transmitter top
// Timing, period scheduling and three TMDS channels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module hdmi_tx
#(
    parameter int h_active      = 1280,
    parameter int h_front       = 110,
    parameter int h_sync        = 40,
    parameter int h_blank       = 370,
    parameter int v_active      = 720,
    parameter int v_blank       = 30,
    parameter int island_offset = 4
)
(
    input  logic        clk_pixel,
    input  logic        rst,
    input  logic [23:0] pixel_data,
    input  logic        pixel_valid,
    output logic        pixel_ready,
    input  logic [8:0]  aux_data,
    input  logic        aux_valid,
    output logic        aux_ready,
    output logic [9:0]  tmds_ch0,
    output logic [9:0]  tmds_ch1,
    output logic [9:0]  tmds_ch2
);

    localparam int column_w = $clog2(h_active + h_blank);
    localparam int row_w    = $clog2(v_active + v_blank);

    logic [column_w-1:0]  column;
    logic [row_w-1:0]     row;
    logic                 hsync;
    logic                 vsync;
    logic                 active;
    hdmi_pkg::tmds_mode_e mode;
    logic [23:0]          video_data;
    logic [11:0]          island_data;
    logic [5:0]           control_data;

    video_timing #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync),
        .h_blank(h_blank), .v_active(v_active), .v_blank(v_blank)
    ) timing (
        .clk_pixel(clk_pixel), .rst(rst), .column(column), .row(row),
        .hsync(hsync), .vsync(vsync), .active(active)
    );

    period_scheduler #(
        .h_active(h_active), .h_blank(h_blank), .v_active(v_active),
        .v_blank(v_blank), .island_offset(island_offset)
    ) scheduler (
        .clk_pixel(clk_pixel), .rst(rst), .column(column), .row(row),
        .hsync(hsync), .vsync(vsync), .active(active),
        .pixel_data(pixel_data), .pixel_valid(pixel_valid), .pixel_ready(pixel_ready),
        .aux_data(aux_data), .aux_valid(aux_valid), .aux_ready(aux_ready),
        .mode(mode), .video_data(video_data), .island_data(island_data),
        .control_data(control_data)
    );

    // Blue on channel 0, green on 1, red on 2
    tmds_channel #(.CN(0)) channel0 (
        .clk_pixel(clk_pixel), .rst(rst), .video_data(video_data[7:0]),
        .data_island_data(island_data[3:0]), .control_data(control_data[1:0]),
        .mode(mode), .tmds(tmds_ch0)
    );

    tmds_channel #(.CN(1)) channel1 (
        .clk_pixel(clk_pixel), .rst(rst), .video_data(video_data[15:8]),
        .data_island_data(island_data[7:4]), .control_data(control_data[3:2]),
        .mode(mode), .tmds(tmds_ch1)
    );

    tmds_channel #(.CN(2)) channel2 (
        .clk_pixel(clk_pixel), .rst(rst), .video_data(video_data[23:16]),
        .data_island_data(island_data[11:8]), .control_data(control_data[5:4]),
        .mode(mode), .tmds(tmds_ch2)
    );

endmodule

// ==== src/tmds_channel.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TMDS channel encoder
// 8b/10b video, control, TERC4 and guard band characters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tmds_channel
#(
    parameter int CN = 0
)
(
    input  logic                 clk_pixel,
    input  logic                 rst,
    input  logic [7:0]           video_data,
    input  logic [3:0]           data_island_data,
    input  logic [1:0]           control_data,
    input  hdmi_pkg::tmds_mode_e mode,
    output logic [9:0]           tmds
);

    function automatic logic [9:0] control_code(input logic [1:0] c);
        case (c)
            2'b00:   control_code = hdmi_pkg::tmds_reset_code;
            2'b01:   control_code = 10'b0010101011;
            2'b10:   control_code = 10'b0101010100;
            default: control_code = 10'b1010101011;
        endcase
    endfunction

    function automatic logic [9:0] terc4_code(input logic [3:0] d);
        case (d)
            4'h0:    terc4_code = 10'b1010011100;
            4'h1:    terc4_code = 10'b1001100011;
            4'h2:    terc4_code = 10'b1011100100;
            4'h3:    terc4_code = 10'b1011100010;
            4'h4:    terc4_code = 10'b0101110001;
            4'h5:    terc4_code = 10'b0100011110;
            4'h6:    terc4_code = 10'b0110001110;
            4'h7:    terc4_code = 10'b0100111100;
            4'h8:    terc4_code = 10'b1011001100;
            4'h9:    terc4_code = 10'b0100111001;
            4'ha:    terc4_code = 10'b0110011100;
            4'hb:    terc4_code = 10'b1011000110;
            4'hc:    terc4_code = 10'b1010001110;
            4'hd:    terc4_code = 10'b1001110001;
            4'he:    terc4_code = 10'b0101100011;
            default: terc4_code = 10'b1011000011;
        endcase
    endfunction

    logic [3:0]        ones_d;
    logic              use_xnor;
    logic [8:0]        q_m;
    logic [3:0]        ones_qm;
    logic signed [4:0] n1_qm;
    logic signed [4:0] n0_qm;
    logic signed [4:0] acc;
    logic signed [4:0] acc_add;
    logic [9:0]        video_code;
    logic [9:0]        video_guard;
    logic [9:0]        island_guard;

    // Transition minimizing stage
    always_comb
    begin
        ones_d = '0;
        for (int i = 0; i < 8; i++)
            ones_d = ones_d + 4'(video_data[i]);
        use_xnor = (ones_d > 4'd4) || (ones_d == 4'd4 && !video_data[0]);
        q_m[0] = video_data[0];
        for (int i = 1; i < 8; i++)
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ video_data[i]) : (q_m[i-1] ^ video_data[i]);
        q_m[8] = ~use_xnor;
        ones_qm = '0;
        for (int i = 0; i < 8; i++)
            ones_qm = ones_qm + 4'(q_m[i]);
        n1_qm = {1'b0, ones_qm};
        n0_qm = 5'sd8 - n1_qm;
    end

    // DC balancing against the running disparity
    always_comb
    begin
        if (acc == 5'sd0 || n1_qm == n0_qm)
        begin
            video_code = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            acc_add    = q_m[8] ? (n1_qm - n0_qm) : (n0_qm - n1_qm);
        end
        else if ((acc > 5'sd0 && n1_qm > n0_qm) || (acc < 5'sd0 && n1_qm < n0_qm))
        begin
            video_code = {1'b1, q_m[8], ~q_m[7:0]};
            acc_add    = (n0_qm - n1_qm) + (q_m[8] ? 5'sd2 : 5'sd0);
        end
        else
        begin
            video_code = {1'b0, q_m[8], q_m[7:0]};
            acc_add    = (n1_qm - n0_qm) - (q_m[8] ? 5'sd0 : 5'sd2);
        end
    end

    // Disparity only carries across consecutive video characters
    always_ff @(posedge clk_pixel)
    begin
        if (rst || mode != hdmi_pkg::mode_video)
            acc <= 5'sd0;
        else
            acc <= acc + acc_add;
    end

    // Guard bands differ per channel; channel 0 island guard carries hsync/vsync
    assign video_guard  = (CN == 1) ? 10'b0100110011 : 10'b1011001100;
    assign island_guard = (CN == 0) ? terc4_code({2'b11, control_data}) : 10'b0100110011;

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
            tmds <= hdmi_pkg::tmds_reset_code;
        else
        begin
            case (mode)
                hdmi_pkg::mode_video:        tmds <= video_code;
                hdmi_pkg::mode_video_guard:  tmds <= video_guard;
                hdmi_pkg::mode_island:       tmds <= terc4_code(data_island_data);
                hdmi_pkg::mode_island_guard: tmds <= island_guard;
                default:                     tmds <= control_code(control_data);
            endcase
        end
    end

endmodule

// ==== src/period_scheduler.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link period scheduler
// Picks the period per clock, registers channel mode and data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module period_scheduler
#(
    parameter int h_active      = 1280,
    parameter int h_blank       = 370,
    parameter int v_active      = 720,
    parameter int v_blank       = 30,
    parameter int island_offset = 4
)
(
    input  logic                                     clk_pixel,
    input  logic                                     rst,
    input  logic [$clog2(h_active + h_blank) - 1:0] column,
    input  logic [$clog2(v_active + v_blank) - 1:0] row,
    input  logic                                     hsync,
    input  logic                                     vsync,
    input  logic                                     active,
    input  logic [23:0]                              pixel_data,
    input  logic                                     pixel_valid,
    output logic                                     pixel_ready,
    input  logic [8:0]                               aux_data,
    input  logic                                     aux_valid,
    output logic                                     aux_ready,
    output hdmi_pkg::tmds_mode_e                     mode,
    output logic [23:0]                              video_data,
    output logic [11:0]                              island_data,
    output logic [5:0]                               control_data
);

    localparam int h_total = h_active + h_blank;
    localparam int v_total = v_active + v_blank;
    localparam int cw      = $clog2(h_total);
    localparam int rw      = $clog2(v_total);
    localparam int seq_len = hdmi_pkg::preamble_len + 2 * hdmi_pkg::guard_len
                           + hdmi_pkg::island_len;

    localparam logic [cw-1:0] slot_column    = cw'(h_active + island_offset);
    localparam logic [cw-1:0] preamble_column =
        cw'(h_total - hdmi_pkg::preamble_len - hdmi_pkg::guard_len);
    localparam logic [cw-1:0] guard_column   = cw'(h_total - hdmi_pkg::guard_len);
    localparam logic [rw-1:0] last_row       = rw'(v_total - 1);
    localparam logic [rw-1:0] last_lead_row  = rw'(v_active - 1);

    // Steps within the island sequence
    localparam logic [5:0] lead_guard_step  = 6'(hdmi_pkg::preamble_len);
    localparam logic [5:0] data_step        = 6'(hdmi_pkg::preamble_len + hdmi_pkg::guard_len);
    localparam logic [5:0] trail_guard_step = 6'(hdmi_pkg::preamble_len + hdmi_pkg::guard_len
                                               + hdmi_pkg::island_len);
    localparam logic [5:0] last_step        = 6'(seq_len - 1);

    typedef enum logic [2:0] {
        period_control,
        period_video_preamble,
        period_video_guard,
        period_video,
        period_island_preamble,
        period_island_guard,
        period_island_data
    } period_e;

    period_e              period;
    logic                 island_on;
    logic [5:0]           island_pos;
    logic                 island_now;
    logic [5:0]           island_step;
    logic                 next_row_active;
    logic [3:0]           ctl;
    logic [8:0]           aux_word;
    hdmi_pkg::tmds_mode_e mode_next;
    logic [23:0]          video_next;
    logic [11:0]          island_next;

    // Period decision on the current position
    always_comb
    begin
        next_row_active = (row == last_row) || (row < last_lead_row);
        island_now      = island_on || (column == slot_column && aux_valid);
        island_step     = island_on ? island_pos : '0;

        if (active)
            period = period_video;
        else if (island_now)
        begin
            if (island_step < lead_guard_step)
                period = period_island_preamble;
            else if (island_step < data_step)
                period = period_island_guard;
            else if (island_step < trail_guard_step)
                period = period_island_data;
            else
                period = period_island_guard;
        end
        else if (next_row_active && column >= guard_column)
            period = period_video_guard;
        else if (next_row_active && column >= preamble_column)
            period = period_video_preamble;
        else
            period = period_control;
    end

    // Once started, an island runs its whole sequence
    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            island_on  <= 1'b0;
            island_pos <= '0;
        end
        else
        begin
            island_on  <= island_now && (island_step != last_step);
            island_pos <= island_now ? island_step + 1'b1 : '0;
        end
    end

    assign pixel_ready = active;
    assign aux_ready   = (period == period_island_data);

    // Missing words at a ready slot become zeros
    assign aux_word = aux_valid ? aux_data : '0;

    always_comb
    begin
        ctl         = '0;
        mode_next   = hdmi_pkg::mode_control;
        video_next  = '0;
        island_next = '0;
        unique case (period)
            period_video_preamble:  ctl = hdmi_pkg::ctl_video_preamble;
            period_video_guard:     mode_next = hdmi_pkg::mode_video_guard;
            period_video:
            begin
                mode_next  = hdmi_pkg::mode_video;
                video_next = pixel_valid ? pixel_data : '0;
            end
            period_island_preamble: ctl = hdmi_pkg::ctl_island_preamble;
            period_island_guard:    mode_next = hdmi_pkg::mode_island_guard;
            period_island_data:
            begin
                mode_next   = hdmi_pkg::mode_island;
                // Channel 0 bit 3 is low only on the first data clock
                island_next = {aux_word[8:5], aux_word[4:1],
                               island_step != data_step, aux_word[0], vsync, hsync};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            mode         <= hdmi_pkg::mode_control;
            video_data   <= '0;
            island_data  <= '0;
            control_data <= '0;
        end
        else
        begin
            mode         <= mode_next;
            video_data   <= video_next;
            island_data  <= island_next;
            control_data <= {ctl, vsync, hsync};
        end
    end

endmodule

// ==== src/video_timing.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video timing generator
// Frame position counters with sync and active flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module video_timing
#(
    parameter int h_active = 1280,
    parameter int h_front  = 110,
    parameter int h_sync   = 40,
    parameter int h_blank  = 370,
    parameter int v_active = 720,
    parameter int v_blank  = 30
)
(
    input  logic                                     clk_pixel,
    input  logic                                     rst,
    output logic [$clog2(h_active + h_blank) - 1:0] column,
    output logic [$clog2(v_active + v_blank) - 1:0] row,
    output logic                                     hsync,
    output logic                                     vsync,
    output logic                                     active
);

    localparam int h_total = h_active + h_blank;
    localparam int v_total = v_active + v_blank;
    localparam int cw      = $clog2(h_total);
    localparam int rw      = $clog2(v_total);

    localparam logic [cw-1:0] last_column = cw'(h_total - 1);
    localparam logic [cw-1:0] sync_first  = cw'(h_active + h_front);
    localparam logic [cw-1:0] sync_last   = cw'(h_active + h_front + h_sync - 1);
    localparam logic [cw-1:0] active_cols = cw'(h_active);
    localparam logic [rw-1:0] last_row    = rw'(v_total - 1);
    localparam logic [rw-1:0] active_rows = rw'(v_active);

    // Reset parks on the final position so the first advance lands on 0,0
    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            column <= last_column;
            row    <= last_row;
        end
        else if (column == last_column)
        begin
            column <= '0;
            row    <= (row == last_row) ? '0 : row + 1'b1;
        end
        else
        begin
            column <= column + 1'b1;
        end
    end

    assign hsync  = (column >= sync_first) && (column <= sync_last);
    // vsync covers the first blank row
    assign vsync  = (row == active_rows);
    assign active = (column < active_cols) && (row < active_rows);

endmodule

// ==== src/hdmi_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HDMI transmit definitions
// Channel coding modes, control patterns, period lengths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package hdmi_pkg;

    // Coding mode of one TMDS channel
    typedef enum logic [2:0] {
        mode_control      = 3'd0,
        mode_video        = 3'd1,
        mode_video_guard  = 3'd2,
        mode_island       = 3'd3,
        mode_island_guard = 3'd4
    } tmds_mode_e;

    // Period lengths in pixel clocks
    localparam int preamble_len = 8;
    localparam int guard_len    = 2;
    localparam int island_len   = 32;

    // CTL0..CTL3 patterns with CTL0 in bit 0
    localparam logic [3:0] ctl_video_preamble  = 4'b0001;
    localparam logic [3:0] ctl_island_preamble = 4'b0101;

    // Control code for C1 C0 = 00
    localparam logic [9:0] tmds_reset_code = 10'b1101010100;

endpackage
